// ==== source/muldiv_macros.svh ====
/*
 * width macros for the iterative multiply/divide unit, include where widths are needed
 */
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// operand width of the processor datapath
`define MULDIV_XLEN 32

// full product and packed quotient/remainder width
`define MULDIV_DLEN (2 * `MULDIV_XLEN)

// iteration counter, one bit per halving of the operand width
`define MULDIV_CNTW $clog2(`MULDIV_XLEN)

`endif

// ==== source/muldiv_msg_pkg.sv ====
/*
 * request and response message types for the multiply/divide unit
 */
`include "muldiv_macros.svh"

package muldiv_msg_pkg;

  // function select carried in each request
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

  // request word, fn on top then both operands
  typedef struct packed {
    muldiv_fn_t               fn;
    logic [`MULDIV_XLEN-1:0]  a;
    logic [`MULDIV_XLEN-1:0]  b;
  } muldiv_req_t;

  // divide view of the response, remainder in the upper half
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] rem;
    logic [`MULDIV_XLEN-1:0] quot;
  } muldiv_div_res_t;

  // one response word, read as a product or as quotient/remainder
  typedef union packed {
    logic signed [`MULDIV_DLEN-1:0] product;
    muldiv_div_res_t                div;
  } muldiv_result_t;

endpackage

// ==== source/muldiv_ctrl_pkg.sv ====
/*
 * controller state and datapath control types shared by the multiplier and divider
 */
package muldiv_ctrl_pkg;

  // iterative unit states
  // idle accepts, calc iterates, done holds the response
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_t;

  // controls from a controller into its datapath
  typedef struct packed {
    // capture operands, clear the partial result
    logic load;
    // one shift/add or shift/subtract iteration
    logic step;
  } iter_ctl_t;

endpackage

// ==== source/int_mul_dpath.sv ====
/*
 * sign-magnitude shift/add multiplier datapath with one partial product per
 * step and the product negated on the way out when the operand signs differ
 */
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module int_mul_dpath
  import muldiv_msg_pkg::*;
  import muldiv_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  iter_ctl_t      ctl,
  input  muldiv_req_t    req,
  output muldiv_result_t result
);

  //--------------------------------------------------------------------
  // operand magnitudes
  //--------------------------------------------------------------------

  logic                    sign_a;
  logic                    sign_b;
  logic [`MULDIV_XLEN-1:0] mag_a;
  logic [`MULDIV_XLEN-1:0] mag_b;

  assign sign_a = req.a[`MULDIV_XLEN-1];
  assign sign_b = req.b[`MULDIV_XLEN-1];

  // two's complement magnitude where the most negative value stays as is
  assign mag_a = sign_a ? (~req.a + 1'b1) : req.a;
  assign mag_b = sign_b ? (~req.b + 1'b1) : req.b;

  //--------------------------------------------------------------------
  // iteration registers
  //--------------------------------------------------------------------

  logic                    neg_reg;
  logic [`MULDIV_DLEN-1:0] mcand_reg;
  logic [`MULDIV_XLEN-1:0] mplier_reg;
  logic [`MULDIV_DLEN-1:0] product_reg;
  logic [`MULDIV_DLEN-1:0] product_add;

  // add the shifted multiplicand only when the current multiplier bit is set
  assign product_add = mplier_reg[0] ? (product_reg + mcand_reg) : product_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      neg_reg     <= 1'b0;
      product_reg <= '0;
    end else if (ctl.load) begin
      neg_reg     <= sign_a ^ sign_b;
      product_reg <= '0;
    end else if (ctl.step) begin
      product_reg <= product_add;
    end
  end

  // operand shift registers
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      // multiplicand zero extended to the full product width
      mcand_reg  <= {{`MULDIV_XLEN{1'b0}}, mag_a};
      mplier_reg <= mag_b;
    end else if (ctl.step) begin
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  //--------------------------------------------------------------------
  // sign fix-up
  //--------------------------------------------------------------------

  always_comb begin
    result.product = neg_reg ? (~product_reg + 1'b1) : product_reg;
  end

endmodule

// ==== source/int_mul_ctrl.sv ====
/*
 * multiplier controller: accepts a request in idle, steps the datapath for
 * one iteration per operand bit, then holds the response until it is taken
 */
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module int_mul_ctrl
  import muldiv_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  output logic      resp_val,
  input  logic      resp_rdy,
  output iter_ctl_t ctl
);

  iter_state_t             state;
  iter_state_t             state_next;
  logic [`MULDIV_CNTW-1:0] count;
  logic                    last_iter;

  // operand width is a power of two, so the last step is an all-ones count
  assign last_iter = &count;

  //--------------------------------------------------------------------
  // state and counter
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (ctl.load) begin
        count <= '0;
      end else if (ctl.step) begin
        count <= count + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------
  // next state and outputs
  //--------------------------------------------------------------------

  always_comb begin
    state_next = state;
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    ctl        = '0;
    case (state)
      ST_IDLE: begin
        req_rdy  = 1'b1;
        // load on the accepting edge itself
        ctl.load = req_val;
        if (req_val) state_next = ST_CALC;
      end
      ST_CALC: begin
        ctl.step = 1'b1;
        if (last_iter) state_next = ST_DONE;
      end
      ST_DONE: begin
        resp_val = 1'b1;
        // back to idle on the edge the response transfers
        if (resp_rdy) state_next = ST_IDLE;
      end
      default: state_next = ST_IDLE;
    endcase
  end

endmodule

// ==== source/int_div_dpath.sv ====
/*
 * sign-magnitude restoring divider datapath that produces one quotient bit
 * per step and applies the quotient and remainder signs on the way out
 */
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module int_div_dpath
  import muldiv_msg_pkg::*;
  import muldiv_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  iter_ctl_t      ctl,
  input  muldiv_req_t    req,
  output muldiv_result_t result
);

  //--------------------------------------------------------------------
  // operand decode
  //--------------------------------------------------------------------

  logic                    is_signed;
  logic                    neg_a;
  logic                    neg_b;
  logic [`MULDIV_XLEN-1:0] mag_a;
  logic [`MULDIV_XLEN-1:0] mag_b;

  assign is_signed = (req.fn == FN_DIV);

  // divu treats both operands as raw unsigned values
  assign neg_a = is_signed & req.a[`MULDIV_XLEN-1];
  assign neg_b = is_signed & req.b[`MULDIV_XLEN-1];
  assign mag_a = neg_a ? (~req.a + 1'b1) : req.a;
  assign mag_b = neg_b ? (~req.b + 1'b1) : req.b;

  //--------------------------------------------------------------------
  // iteration registers
  //--------------------------------------------------------------------

  // dividend bits leave the top of dq_reg while quotient bits enter the bottom
  logic                    signed_reg;
  logic                    rem_neg_reg;
  logic                    quot_neg_reg;
  logic [`MULDIV_XLEN-1:0] divisor_reg;
  logic [`MULDIV_XLEN-1:0] dq_reg;
  logic [`MULDIV_XLEN-1:0] rem_reg;

  logic [`MULDIV_XLEN:0]   rem_shift;
  logic [`MULDIV_XLEN+1:0] diff;
  logic                    borrow;

  // bring down the next dividend bit
  assign rem_shift = {rem_reg, dq_reg[`MULDIV_XLEN-1]};

  // trial subtract with a spare bit so the borrow is never lost
  assign diff   = {1'b0, rem_shift} - {2'b00, divisor_reg};
  assign borrow = diff[`MULDIV_XLEN+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      signed_reg   <= 1'b0;
      rem_neg_reg  <= 1'b0;
      quot_neg_reg <= 1'b0;
      rem_reg      <= '0;
    end else if (ctl.load) begin
      signed_reg   <= is_signed;
      // raw operand signs that the output stage applies only for div
      // remainder follows the dividend sign
      rem_neg_reg  <= req.a[`MULDIV_XLEN-1];
      quot_neg_reg <= req.a[`MULDIV_XLEN-1] ^ req.b[`MULDIV_XLEN-1];
      rem_reg      <= '0;
    end else if (ctl.step) begin
      // restore on borrow by keeping the shifted remainder
      rem_reg      <= borrow ? rem_shift[`MULDIV_XLEN-1:0] : diff[`MULDIV_XLEN-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.load) begin
      divisor_reg <= mag_b;
      dq_reg      <= mag_a;
    end else if (ctl.step) begin
      dq_reg      <= {dq_reg[`MULDIV_XLEN-2:0], ~borrow};
    end
  end

  //--------------------------------------------------------------------
  // sign fix-up
  //--------------------------------------------------------------------

  // a zero divisor never borrows so the quotient comes out all ones
  // with the dividend left in the remainder
  always_comb begin
    result.div.quot = (signed_reg & quot_neg_reg) ? (~dq_reg + 1'b1) : dq_reg;
    result.div.rem  = (signed_reg & rem_neg_reg) ? (~rem_reg + 1'b1) : rem_reg;
  end

endmodule

// ==== source/int_div_ctrl.sv ====
/*
 * divider controller: same idle/calc/done handshake as the multiplier,
 * with its own state and iteration counter
 */
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module int_div_ctrl
  import muldiv_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  output logic      resp_val,
  input  logic      resp_rdy,
  output iter_ctl_t ctl
);

  iter_state_t             state;
  logic [`MULDIV_CNTW-1:0] count;
  logic                    req_go;
  logic                    resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  //--------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // one quotient bit per cycle, leave after the last one
          count <= count + 1'b1;
          if (&count) state <= ST_DONE;
        end
        ST_DONE: begin
          if (resp_go) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // outputs decoded from state
  //--------------------------------------------------------------------

  always_comb begin
    req_rdy  = (state == ST_IDLE);
    resp_val = (state == ST_DONE);
    ctl.load = req_go;
    ctl.step = (state == ST_CALC);
  end

endmodule

// ==== source/int_muldiv_iterative.sv ====
/*
 * iterative multiply/divide unit top level: steers each request to the
 * multiplier or divider by fn and merges the two response channels
 */
`timescale 1ns/1ps

module int_muldiv_iterative
  import muldiv_msg_pkg::*;
  import muldiv_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           req_val,
  output logic           req_rdy,
  input  muldiv_req_t    req,
  output logic           resp_val,
  input  logic           resp_rdy,
  output muldiv_result_t resp
);

  //--------------------------------------------------------------------
  // request dispatch
  //--------------------------------------------------------------------

  logic           is_mul;
  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           div_req_val;
  logic           div_req_rdy;
  logic           div_resp_val;
  iter_ctl_t      mul_ctl;
  iter_ctl_t      div_ctl;
  muldiv_result_t mul_result;
  muldiv_result_t div_result;

  assign is_mul = (req.fn == FN_MUL);

  // one operation in flight, so accept only with both units idle
  assign req_rdy = mul_req_rdy & div_req_rdy;

  // gate on req_rdy so an idle unit cannot start while the other is done
  assign mul_req_val = req_val & req_rdy & is_mul;
  assign div_req_val = req_val & req_rdy & ~is_mul;

  //--------------------------------------------------------------------
  // multiplier
  //--------------------------------------------------------------------

  int_mul_ctrl mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (mul_ctl)
  );

  int_mul_dpath mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .ctl    (mul_ctl),
    .req    (req),
    .result (mul_result)
  );

  //--------------------------------------------------------------------
  // divider
  //--------------------------------------------------------------------

  int_div_ctrl div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (div_ctl)
  );

  int_div_dpath div_dpath (
    .clk    (clk),
    .reset  (reset),
    .ctl    (div_ctl),
    .req    (req),
    .result (div_result)
  );

  // response merge
  // at most one unit is ever done, resp_rdy only matters to that one
  assign resp_val = mul_resp_val | div_resp_val;
  assign resp     = mul_resp_val ? mul_result : div_result;

endmodule

// ==== verif/tb_muldiv_ref.svh ====
/*
 * reference model for the multiply/divide testbench, included inside the
 * testbench module after the message package import
 */
`ifndef TB_MULDIV_REF_SVH
`define TB_MULDIV_REF_SVH

// printable function name for error lines
function automatic string fn_name(input muldiv_fn_t fn);
  case (fn)
    FN_MUL:  return "mul";
    FN_DIV:  return "div";
    FN_DIVU: return "divu";
    default: return "bad";
  endcase
endfunction

// expected response word for one request
function automatic muldiv_result_t expected_result(input muldiv_req_t r);
  muldiv_result_t                 res;
  logic signed [`MULDIV_DLEN-1:0] sa;
  logic signed [`MULDIV_DLEN-1:0] sb;
  logic [`MULDIV_XLEN-1:0]        ma;
  logic [`MULDIV_XLEN-1:0]        mb;
  logic [`MULDIV_XLEN-1:0]        q;
  logic [`MULDIV_XLEN-1:0]        rm;
  logic                           na;
  logic                           nb;
  res = '0;
  if (r.fn == FN_MUL) begin
    // full signed product, low 64 bits of a 64x64 multiply
    sa = {{`MULDIV_XLEN{r.a[`MULDIV_XLEN-1]}}, r.a};
    sb = {{`MULDIV_XLEN{r.b[`MULDIV_XLEN-1]}}, r.b};
    res.product = sa * sb;
  end else begin
    // signs only count for the signed divide
    na = (r.fn == FN_DIV) && r.a[`MULDIV_XLEN-1];
    nb = (r.fn == FN_DIV) && r.b[`MULDIV_XLEN-1];
    ma = na ? -r.a : r.a;
    mb = nb ? -r.b : r.b;
    if (mb == '0) begin
      // zero divisor gives an all-ones magnitude and keeps the dividend
      q  = '1;
      rm = ma;
    end else begin
      q  = ma / mb;
      rm = ma % mb;
    end
    // quotient takes the xor of the signs, remainder the dividend sign
    if (na ^ nb) q = -q;
    if (na) rm = -rm;
    res.div.quot = q;
    res.div.rem  = rm;
  end
  return res;
endfunction

`endif

// ==== verif/tb_int_muldiv.sv ====
/*
 * testbench for the iterative multiply/divide unit with corner and random
 * requests, a reference compare and back-pressure and latency checks
 */
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module tb_int_muldiv
  import muldiv_msg_pkg::*;
();

  // edges per wait loop before giving up
  localparam int TIMEOUT = 200;
  // edges from the accepting edge to the first edge that sees resp_val
  localparam int LATENCY = `MULDIV_XLEN + 1;

  logic           clk;
  logic           reset;
  logic           req_val;
  logic           req_rdy;
  muldiv_req_t    req;
  logic           resp_val;
  logic           resp_rdy;
  muldiv_result_t resp;

  int          value_errors;
  int          proto_errors;
  int          sent;
  int          checked;
  // accepted requests waiting for their response
  muldiv_req_t pending[$];

  `include "tb_muldiv_ref.svh"

  int_muldiv_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------
  // response compare
  // --------------------------------------------------------------------

  always @(posedge clk) begin : compare
    muldiv_req_t    r;
    muldiv_result_t exp;
    if (!reset && resp_val && resp_rdy) begin
      if (pending.size() == 0) begin
        proto_errors++;
        $display("Error at %0t: response with no request outstanding", $time);
      end else begin
        r   = pending.pop_front();
        exp = expected_result(r);
        checked++;
        if (resp !== exp) begin
          value_errors++;
          $display("Error at %0t: %s a=%h b=%h expected %h got %h",
                   $time, fn_name(r.fn), r.a, r.b, exp, resp);
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------

  task automatic report_proto(input string msg);
    proto_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: the %s never completed", $time, what);
    $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
    $display("Done: errors found");
    $finish;
  endtask

  // half of the random requests see up to 20 cycles of back-pressure
  function automatic int pick_stall();
    if ($urandom % 2) return $urandom % 21;
    return 0;
  endfunction

  // one full request/response exchange
  task automatic run_op(input muldiv_fn_t fn, input logic [`MULDIV_XLEN-1:0] a,
                        input logic [`MULDIV_XLEN-1:0] b, input int stall);
    muldiv_req_t    r;
    muldiv_result_t held;
    int             edges;
    int             i;
    bit             seen;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    @(posedge clk);
    req_val  <= 1'b1;
    req      <= r;
    resp_rdy <= (stall == 0);
    edges = 0;
    seen  = 0;
    while (!seen && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      seen = req_rdy;
    end
    if (!seen) stop_on_timeout("request handshake");
    pending.push_back(r);
    sent++;
    req_val <= 1'b0;
    // count edges from the accepting one
    edges = 0;
    seen  = 0;
    while (!seen && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      seen = resp_val;
    end
    if (!seen) stop_on_timeout("response valid wait");
    if (edges != LATENCY) begin
      report_proto($sformatf("resp_val seen after %0d edges, expected %0d", edges, LATENCY));
    end
    if (req_rdy) report_proto("req_rdy high while a response is pending");
    if (stall > 0) begin
      held = resp;
      for (i = 0; i < stall; i++) begin
        @(posedge clk);
        if (!resp_val || resp !== held || req_rdy) begin
          report_proto("response not held steady under back-pressure");
        end
      end
      resp_rdy <= 1'b1;
      edges = 0;
      seen  = 0;
      while (!seen && edges < TIMEOUT) begin
        @(posedge clk);
        edges++;
        seen = resp_val && resp_rdy;
      end
      if (!seen) stop_on_timeout("response handshake");
    end
    // unit back in idle right after the transfer
    @(posedge clk);
    if (!req_rdy) report_proto("req_rdy low in the cycle after the response");
  endtask

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------

  initial begin : stimulus
    logic [`MULDIV_XLEN-1:0] corners [5];
    int unsigned             seed;
    int                      i;
    int                      j;
    muldiv_fn_t              fn;
    clk          = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req          = '0;
    resp_rdy     = 1'b0;
    value_errors = 0;
    proto_errors = 0;
    sent         = 0;
    checked      = 0;
    seed         = 32'hcc41_51e9;
    void'($urandom(seed));
    corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (!req_rdy || resp_val) report_proto("handshake not idle after reset");
    // corner pairs including zero divisors and most negative over -1
    for (i = 0; i < 5; i++) begin
      for (j = 0; j < 5; j++) begin
        run_op(FN_MUL, corners[i], corners[j], 0);
        run_op(FN_DIV, corners[i], corners[j], 0);
        run_op(FN_DIVU, corners[i], corners[j], 0);
      end
    end
    for (i = 0; i < 200; i++) begin
      run_op(FN_MUL, $urandom, $urandom, pick_stall());
    end
    // shorter divisors so quotients spread over the whole range
    for (i = 0; i < 200; i++) begin
      if ($urandom % 2) begin
        fn = FN_DIV;
      end else begin
        fn = FN_DIVU;
      end
      run_op(fn, $urandom, $urandom >> ($urandom % 32), pick_stall());
    end
    repeat (2) @(posedge clk);
    $display("checked %0d of %0d responses, value errors %0d, protocol errors %0d",
             checked, sent, value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
+incdir+verif
source/muldiv_msg_pkg.sv
source/muldiv_ctrl_pkg.sv
source/int_mul_dpath.sv
source/int_mul_ctrl.sv
source/int_div_dpath.sv
source/int_div_ctrl.sv
source/int_muldiv_iterative.sv
verif/tb_int_muldiv.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_int_muldiv -o tb_int_muldiv

output="$(./obj_dir/tb_int_muldiv)"
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
